/* Makefile */
VERILATOR ?= verilator
TOP       ?= task_unit_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/task_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module task_dispatch #(
   parameter int LOG_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  rstn,
   task_queue_if.reader          q,
   input  logic                  almost_full,
   input  logic [LOG_DEPTH:0]    spill_size,
   output logic                  overflow_valid,
   input  logic                  overflow_ready,
   output task_unit_pkg::task_t  overflow_data,
   output logic                  task_deq_valid,
   input  logic                  task_deq_ready,
   output task_unit_pkg::task_t  task_deq_data,
   output logic                  splitter_deq_valid,
   input  logic                  splitter_deq_ready,
   output task_unit_pkg::task_t  splitter_deq_data
);
   import task_unit_pkg::*;

   logic [LOG_DEPTH:0] spills_remaining;
   logic               spilling;
   logic               head_is_splitter;

   assign spilling         = (spills_remaining != '0);
   assign head_is_splitter = (q.rd_data.ttype == TASK_TYPE_SPLITTER);

   // Start a new burst only once the previous one has drained
   always_ff @(posedge clk) begin
      if (!rstn) begin
         spills_remaining <= '0;
      end else if (!spilling && almost_full) begin
         spills_remaining <= spill_size;
      end else if (overflow_valid && overflow_ready) begin
         spills_remaining <= spills_remaining - 1'b1;
      end
   end

   assign overflow_valid     = !q.empty & spilling;
   assign task_deq_valid     = !q.empty & !spilling & !head_is_splitter;
   assign splitter_deq_valid = !q.empty & !spilling & head_is_splitter;

   assign overflow_data     = q.rd_data;
   assign task_deq_data     = q.rd_data;
   assign splitter_deq_data = q.rd_data;

   assign q.rd_en = (overflow_valid & overflow_ready)
                  | (task_deq_valid & task_deq_ready)
                  | (splitter_deq_valid & splitter_deq_ready);

   // A stalled burst keeps the same head task
   assert property (@(posedge clk) disable iff (!rstn)
      (overflow_valid && !overflow_ready) |=> overflow_valid && $stable(overflow_data))
      else $error("task_dispatch: stalled overflow task changed");

endmodule

`default_nettype wire

/* source/task_enq_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module task_enq_arbiter #(
   parameter int LOG_DEPTH = 4
) (
   input  logic                  task_enq_valid,
   output logic                  task_enq_ready,
   input  task_unit_pkg::task_t  task_enq_data,
   input  logic                  coal_child_valid,
   output logic                  coal_child_ready,
   input  task_unit_pkg::task_t  coal_child_data,
   input  logic [LOG_DEPTH:0]    spill_threshold,
   task_queue_if.writer          q,
   output logic                  almost_full
);
   logic coal_child_fire;
   logic task_enq_fire;

   assign almost_full = (q.count > spill_threshold);

   // Coalescer children win, and bypass the threshold
   assign coal_child_ready = coal_child_valid & !q.full;
   assign task_enq_ready   = !coal_child_valid & !almost_full & !q.full;

   assign coal_child_fire = coal_child_valid & coal_child_ready;
   assign task_enq_fire   = task_enq_valid & task_enq_ready;

   assign q.wr_en   = coal_child_fire | task_enq_fire;
   assign q.wr_data = coal_child_valid ? coal_child_data : task_enq_data;

endmodule

`default_nettype wire

/* source/task_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module task_queue #(
   parameter int LOG_DEPTH = 4
) (
   input logic          clk,
   input logic          rstn,
   task_queue_if.store  q
);
   import task_unit_pkg::*;

   localparam int DEPTH = 1 << LOG_DEPTH;

   task_t                mem [DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH:0]   count;

   // Storage
   always_ff @(posedge clk) begin
      if (q.wr_en) begin
         mem[wr_ptr] <= q.wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (q.wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (q.rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (q.wr_en && !q.rd_en) begin
            count <= count + 1'b1;
         end else if (!q.wr_en && q.rd_en) begin
            count <= count - 1'b1;
         end
      end
   end

   // Head entry falls through
   assign q.rd_data = mem[rd_ptr];
   assign q.count   = count;
   assign q.empty   = (count == '0);
   assign q.full    = (count == (LOG_DEPTH+1)'(DEPTH));

   assert property (@(posedge clk) disable iff (!rstn) q.wr_en |-> !q.full)
      else $error("task_queue: write while full");

   assert property (@(posedge clk) disable iff (!rstn) q.rd_en |-> !q.empty)
      else $error("task_queue: read while empty");

endmodule

`default_nettype wire

/* source/task_queue_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface task_queue_if #(
   parameter int LOG_DEPTH = 4
);
   import task_unit_pkg::*;

   logic                 wr_en;
   task_t                wr_data;
   logic                 rd_en;
   task_t                rd_data;
   logic                 empty;
   logic                 full;
   logic [LOG_DEPTH:0]   count;

   modport writer (output wr_en, output wr_data, input full, input count);

   modport reader (output rd_en, input rd_data, input empty, input count);

   modport store (input wr_en, input wr_data, input rd_en,
                  output rd_data, output empty, output full, output count);

endinterface

`default_nettype wire

/* source/task_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module task_unit #(
   parameter int LOG_DEPTH = 4
) (
   input  logic                                       clk,
   input  logic                                       rstn,

   // New tasks from the tile
   input  logic                                       task_enq_valid,
   output logic                                       task_enq_ready,
   input  task_unit_pkg::task_t                       task_enq_data,

   // Children from the spill coalescer
   input  logic                                       coal_child_valid,
   output logic                                       coal_child_ready,
   input  task_unit_pkg::task_t                       coal_child_data,

   output logic                                       overflow_valid,
   input  logic                                       overflow_ready,
   output task_unit_pkg::task_t                       overflow_data,

   output logic                                       task_deq_valid,
   input  logic                                       task_deq_ready,
   output task_unit_pkg::task_t                       task_deq_data,

   output logic                                       splitter_deq_valid,
   input  logic                                       splitter_deq_ready,
   output task_unit_pkg::task_t                       splitter_deq_data,

   // Register access
   input  logic                                       psel,
   input  logic                                       penable,
   input  logic                                       pwrite,
   input  logic [task_unit_pkg::APB_ADDR_WIDTH-1:0]   paddr,
   input  logic [task_unit_pkg::APB_DATA_WIDTH-1:0]   pwdata,
   output logic [task_unit_pkg::APB_DATA_WIDTH-1:0]   prdata,
   output logic                                       pready,

   output logic                                       full,
   output logic                                       almost_full,
   output logic                                       empty
);
   logic [LOG_DEPTH:0] spill_threshold;
   logic [LOG_DEPTH:0] spill_size;
   logic               task_enq_fire;
   logic               coal_child_fire;
   logic               task_deq_fire;
   logic               splitter_deq_fire;
   logic               overflow_fire;

   task_queue_if #(.LOG_DEPTH(LOG_DEPTH)) tq ();

   task_enq_arbiter #(.LOG_DEPTH(LOG_DEPTH)) u_arbiter (
      .task_enq_valid   (task_enq_valid),
      .task_enq_ready   (task_enq_ready),
      .task_enq_data    (task_enq_data),
      .coal_child_valid (coal_child_valid),
      .coal_child_ready (coal_child_ready),
      .coal_child_data  (coal_child_data),
      .spill_threshold  (spill_threshold),
      .q                (tq.writer),
      .almost_full      (almost_full)
   );

   task_queue #(.LOG_DEPTH(LOG_DEPTH)) u_queue (
      .clk  (clk),
      .rstn (rstn),
      .q    (tq.store)
   );

   task_dispatch #(.LOG_DEPTH(LOG_DEPTH)) u_dispatch (
      .clk                (clk),
      .rstn               (rstn),
      .q                  (tq.reader),
      .almost_full        (almost_full),
      .spill_size         (spill_size),
      .overflow_valid     (overflow_valid),
      .overflow_ready     (overflow_ready),
      .overflow_data      (overflow_data),
      .task_deq_valid     (task_deq_valid),
      .task_deq_ready     (task_deq_ready),
      .task_deq_data      (task_deq_data),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_ready (splitter_deq_ready),
      .splitter_deq_data  (splitter_deq_data)
   );

   assign task_enq_fire     = task_enq_valid & task_enq_ready;
   assign coal_child_fire   = coal_child_valid & coal_child_ready;
   assign task_deq_fire     = task_deq_valid & task_deq_ready;
   assign splitter_deq_fire = splitter_deq_valid & splitter_deq_ready;
   assign overflow_fire     = overflow_valid & overflow_ready;

   task_unit_regs #(.LOG_DEPTH(LOG_DEPTH)) u_regs (
      .clk               (clk),
      .rstn              (rstn),
      .psel              (psel),
      .penable           (penable),
      .pwrite            (pwrite),
      .paddr             (paddr),
      .pwdata            (pwdata),
      .prdata            (prdata),
      .pready            (pready),
      .spill_threshold   (spill_threshold),
      .spill_size        (spill_size),
      .count             (tq.count),
      .task_enq_fire     (task_enq_fire),
      .coal_child_fire   (coal_child_fire),
      .task_deq_fire     (task_deq_fire),
      .splitter_deq_fire (splitter_deq_fire),
      .overflow_fire     (overflow_fire)
   );

   assign full  = tq.full;
   assign empty = tq.empty;

endmodule

`default_nettype wire

/* source/task_unit_pkg.sv */
`default_nettype none

package task_unit_pkg;

   localparam int TS_WIDTH    = 32;
   localparam int HINT_WIDTH  = 32;
   localparam int ARG_WIDTH   = 32;
   localparam int TTYPE_WIDTH = 4;

   // 100 bits, timestamp in the top bits
   typedef struct packed {
      logic [TS_WIDTH-1:0]    ts;
      logic [HINT_WIDTH-1:0]  hint;
      logic [TTYPE_WIDTH-1:0] ttype;
      logic [ARG_WIDTH-1:0]   args;
   } task_t;

   localparam logic [TTYPE_WIDTH-1:0] TASK_TYPE_SPLITTER = 4'd15;

   localparam int APB_ADDR_WIDTH = 8;
   localparam int APB_DATA_WIDTH = 32;

   // Byte addresses of the register block
   typedef enum logic [7:0] {
      REG_SPILL_THRESHOLD = 8'h00,
      REG_SPILL_SIZE      = 8'h04,
      REG_N_TASKS         = 8'h08,
      REG_N_TASK_ENQ      = 8'h10,
      REG_N_COAL_CHILD    = 8'h14,
      REG_N_TASK_DEQ      = 8'h18,
      REG_N_SPLITTER_DEQ  = 8'h1C,
      REG_N_OVERFLOW      = 8'h20
   } reg_addr_e;

   localparam logic [31:0] DEFAULT_SPILL_THRESHOLD = 32'd12;
   localparam logic [31:0] DEFAULT_SPILL_SIZE      = 32'd4;

endpackage

`default_nettype wire

/* source/task_unit_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module task_unit_regs #(
   parameter int LOG_DEPTH = 4
) (
   input  logic                                       clk,
   input  logic                                       rstn,
   input  logic                                       psel,
   input  logic                                       penable,
   input  logic                                       pwrite,
   input  logic [task_unit_pkg::APB_ADDR_WIDTH-1:0]   paddr,
   input  logic [task_unit_pkg::APB_DATA_WIDTH-1:0]   pwdata,
   output logic [task_unit_pkg::APB_DATA_WIDTH-1:0]   prdata,
   output logic                                       pready,
   output logic [LOG_DEPTH:0]                         spill_threshold,
   output logic [LOG_DEPTH:0]                         spill_size,
   input  logic [LOG_DEPTH:0]                         count,
   input  logic                                       task_enq_fire,
   input  logic                                       coal_child_fire,
   input  logic                                       task_deq_fire,
   input  logic                                       splitter_deq_fire,
   input  logic                                       overflow_fire
);
   import task_unit_pkg::*;

   logic        apb_write;
   logic        apb_read;
   logic [31:0] n_task_enq;
   logic [31:0] n_coal_child;
   logic [31:0] n_task_deq;
   logic [31:0] n_splitter_deq;
   logic [31:0] n_overflow;

   // Zero wait states
   assign pready = 1'b1;

   assign apb_write = psel & penable & pwrite;
   assign apb_read  = psel & !pwrite;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         spill_threshold <= DEFAULT_SPILL_THRESHOLD[LOG_DEPTH:0];
         spill_size      <= DEFAULT_SPILL_SIZE[LOG_DEPTH:0];
      end else if (apb_write) begin
         case (paddr)
            REG_SPILL_THRESHOLD: spill_threshold <= pwdata[LOG_DEPTH:0];
            REG_SPILL_SIZE:      spill_size      <= pwdata[LOG_DEPTH:0];
            default: ;
         endcase
      end
   end

   // Event counters
   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_task_enq     <= '0;
         n_coal_child   <= '0;
         n_task_deq     <= '0;
         n_splitter_deq <= '0;
         n_overflow     <= '0;
      end else begin
         if (task_enq_fire) begin
            n_task_enq <= n_task_enq + 1'b1;
         end
         if (coal_child_fire) begin
            n_coal_child <= n_coal_child + 1'b1;
         end
         if (task_deq_fire) begin
            n_task_deq <= n_task_deq + 1'b1;
         end
         if (splitter_deq_fire) begin
            n_splitter_deq <= n_splitter_deq + 1'b1;
         end
         if (overflow_fire) begin
            n_overflow <= n_overflow + 1'b1;
         end
      end
   end

   // Read data held for the whole access, zero when idle
   always_comb begin
      prdata = '0;
      if (apb_read) begin
         case (paddr)
            REG_SPILL_THRESHOLD: prdata = APB_DATA_WIDTH'(spill_threshold);
            REG_SPILL_SIZE:      prdata = APB_DATA_WIDTH'(spill_size);
            REG_N_TASKS:         prdata = APB_DATA_WIDTH'(count);
            REG_N_TASK_ENQ:      prdata = n_task_enq;
            REG_N_COAL_CHILD:    prdata = n_coal_child;
            REG_N_TASK_DEQ:      prdata = n_task_deq;
            REG_N_SPLITTER_DEQ:  prdata = n_splitter_deq;
            REG_N_OVERFLOW:      prdata = n_overflow;
            default:             prdata = '0;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!rstn)
      (psel && penable) |-> $past(psel) && $stable(paddr))
      else $error("task_unit_regs: access phase without matching setup");

endmodule

`default_nettype wire

/* sources.f */
source/task_unit_pkg.sv
source/task_queue_if.sv
source/task_enq_arbiter.sv
source/task_queue.sv
source/task_dispatch.sv
source/task_unit_regs.sv
source/task_unit.sv
tests/task_unit_tb.sv

/* tests/task_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module task_unit_tb;
   import task_unit_pkg::*;

   localparam int LOG_DEPTH  = 4;
   localparam int DEPTH      = 1 << LOG_DEPTH;
   localparam int CLK_PERIOD = 4;
   localparam logic [31:0] CFG_MASK = 32'((1 << (LOG_DEPTH + 1)) - 1);

   // Task counts per test, used to size the watchdog
   localparam int N_FIFO      = 8;
   localparam int N_MIXED     = 10;
   localparam int N_PRIO      = 2;
   localparam int N_FILL      = DEPTH;
   localparam int N_APB_TASKS = 3;
   localparam int N_APB_OPS   = 20;
   localparam int STIM_CYCLES = 5 + 4 * (N_FIFO + N_MIXED + N_PRIO + N_FILL + N_APB_TASKS)
                              + 3 * N_APB_OPS;

   logic clk;
   logic rstn;
   logic task_enq_valid, task_enq_ready, coal_child_valid, coal_child_ready;
   task_t task_enq_data, coal_child_data;
   logic overflow_valid, overflow_ready, task_deq_valid, task_deq_ready;
   logic splitter_deq_valid, splitter_deq_ready;
   task_t overflow_data, task_deq_data, splitter_deq_data;
   logic psel, penable, pwrite, pready;
   logic [APB_ADDR_WIDTH-1:0] paddr;
   logic [APB_DATA_WIDTH-1:0] pwdata, prdata;
   logic full, almost_full, empty;

   int    seed = 32'hc2e8;
   int    error_count = 0;
   int    apb_reads = 0;
   string test_name = "reset";

   // Handshakes captured mid-cycle, applied to the model on the next edge
   logic  snap_rstn = 1'b0;
   logic  snap_enq_fire = 1'b0, snap_coal_fire = 1'b0, snap_ovf_fire = 1'b0;
   logic  snap_deq_fire = 1'b0, snap_split_fire = 1'b0, snap_apb_wr = 1'b0;
   task_t snap_enq_data = '0, snap_coal_data = '0;
   logic [7:0]  snap_paddr = '0;
   logic [31:0] snap_pwdata = '0;

   // Reference model
   task_t model_q[$];
   task_t exp_head = '0;
   int    exp_count = 0, exp_spill = 0, thr_model = 0, size_model = 0;
   int    n_enq = 0, n_coal = 0, n_deq = 0, n_split = 0, n_ovf = 0;
   logic  exp_deq_valid, exp_split_valid, exp_ovf_valid, exp_enq_ready, exp_coal_ready;
   logic [2:0]  exp_status;
   logic [31:0] exp_rdata;

   task_unit #(.LOG_DEPTH(LOG_DEPTH)) u_task_unit (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(negedge clk) begin
      snap_rstn       = rstn;
      snap_enq_fire   = task_enq_valid && task_enq_ready;
      snap_coal_fire  = coal_child_valid && coal_child_ready;
      snap_ovf_fire   = overflow_valid && overflow_ready;
      snap_deq_fire   = task_deq_valid && task_deq_ready;
      snap_split_fire = splitter_deq_valid && splitter_deq_ready;
      snap_enq_data   = task_enq_data;
      snap_coal_data  = coal_child_data;
      snap_apb_wr     = psel && penable && pwrite;
      snap_paddr      = paddr;
      snap_pwdata     = pwdata;
   end

   always @(posedge clk) begin
      if (!snap_rstn) begin
         model_q.delete();
         exp_spill  = 0;
         thr_model  = DEFAULT_SPILL_THRESHOLD;
         size_model = DEFAULT_SPILL_SIZE;
         n_enq      = 0;
         n_coal     = 0;
         n_deq      = 0;
         n_split    = 0;
         n_ovf      = 0;
      end else begin
         // A burst starts only from an idle spill counter
         if (exp_spill == 0 && exp_count > thr_model) begin
            exp_spill = size_model;
         end else if (snap_ovf_fire) begin
            exp_spill--;
         end
         if (snap_ovf_fire || snap_deq_fire || snap_split_fire) begin
            void'(model_q.pop_front());
         end
         if (snap_coal_fire) begin
            model_q.push_back(snap_coal_data);
         end else if (snap_enq_fire) begin
            model_q.push_back(snap_enq_data);
         end
         n_enq   += int'(snap_enq_fire);
         n_coal  += int'(snap_coal_fire);
         n_deq   += int'(snap_deq_fire);
         n_split += int'(snap_split_fire);
         n_ovf   += int'(snap_ovf_fire);
         if (snap_apb_wr && snap_paddr == REG_SPILL_THRESHOLD) begin
            thr_model = snap_pwdata & CFG_MASK;
         end
         if (snap_apb_wr && snap_paddr == REG_SPILL_SIZE) begin
            size_model = snap_pwdata & CFG_MASK;
         end
      end
      exp_count = model_q.size();
      exp_head  = (exp_count != 0) ? model_q[0] : '0;
   end

   always_comb begin
      exp_ovf_valid   = (exp_count != 0) && (exp_spill != 0);
      exp_deq_valid   = (exp_count != 0) && (exp_spill == 0)
                        && (exp_head.ttype != TASK_TYPE_SPLITTER);
      exp_split_valid = (exp_count != 0) && (exp_spill == 0)
                        && (exp_head.ttype == TASK_TYPE_SPLITTER);
      exp_coal_ready  = coal_child_valid && (exp_count < DEPTH);
      exp_enq_ready   = !coal_child_valid && (exp_count <= thr_model) && (exp_count < DEPTH);
      exp_status      = {exp_count == DEPTH, exp_count > thr_model, exp_count == 0};
      case (paddr)
         REG_SPILL_THRESHOLD: exp_rdata = thr_model;
         REG_SPILL_SIZE:      exp_rdata = size_model;
         REG_N_TASKS:         exp_rdata = exp_count;
         REG_N_TASK_ENQ:      exp_rdata = n_enq;
         REG_N_COAL_CHILD:    exp_rdata = n_coal;
         REG_N_TASK_DEQ:      exp_rdata = n_deq;
         REG_N_SPLITTER_DEQ:  exp_rdata = n_split;
         REG_N_OVERFLOW:      exp_rdata = n_ovf;
         default:             exp_rdata = '0;
      endcase
   end

   task automatic report_mismatch(input string what, input logic [99:0] expected,
                                  input logic [99:0] actual);
      error_count++;
      $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
   endtask

   a_deq_valid: assert property (@(negedge clk) disable iff (!rstn)
      task_deq_valid == exp_deq_valid)
      else report_mismatch("task_deq_valid", 100'(exp_deq_valid), 100'(task_deq_valid));
   a_split_valid: assert property (@(negedge clk) disable iff (!rstn)
      splitter_deq_valid == exp_split_valid)
      else report_mismatch("splitter_deq_valid", 100'(exp_split_valid),
                           100'(splitter_deq_valid));
   a_ovf_valid: assert property (@(negedge clk) disable iff (!rstn)
      overflow_valid == exp_ovf_valid)
      else report_mismatch("overflow_valid", 100'(exp_ovf_valid), 100'(overflow_valid));
   a_deq_data: assert property (@(negedge clk) disable iff (!rstn)
      task_deq_valid |-> task_deq_data == exp_head)
      else report_mismatch("task_deq_data", exp_head, task_deq_data);
   a_split_data: assert property (@(negedge clk) disable iff (!rstn)
      splitter_deq_valid |-> splitter_deq_data == exp_head)
      else report_mismatch("splitter_deq_data", exp_head, splitter_deq_data);
   a_ovf_data: assert property (@(negedge clk) disable iff (!rstn)
      overflow_valid |-> overflow_data == exp_head)
      else report_mismatch("overflow_data", exp_head, overflow_data);
   a_prio: assert property (@(negedge clk) disable iff (!rstn)
      (coal_child_valid && task_enq_valid) |-> !task_enq_ready)
      else report_mismatch("task_enq_ready with both valid", 100'(0), 100'(task_enq_ready));
   a_enq_ready: assert property (@(negedge clk) disable iff (!rstn)
      task_enq_ready == exp_enq_ready)
      else report_mismatch("task_enq_ready", 100'(exp_enq_ready), 100'(task_enq_ready));
   a_coal_ready: assert property (@(negedge clk) disable iff (!rstn)
      coal_child_ready == exp_coal_ready)
      else report_mismatch("coal_child_ready", 100'(exp_coal_ready), 100'(coal_child_ready));
   a_status: assert property (@(negedge clk) disable iff (!rstn)
      {full, almost_full, empty} == exp_status)
      else report_mismatch("full/almost_full/empty", 100'(exp_status),
                           100'({full, almost_full, empty}));
   a_prdata: assert property (@(negedge clk) disable iff (!rstn)
      (psel && penable && !pwrite) |-> pready && prdata == exp_rdata)
      else report_mismatch("prdata", 100'(exp_rdata), 100'(prdata));

   task step;
      @(posedge clk);
      #1;
   endtask

   function automatic task_t random_task(input logic splitter_mix);
      task_t       t;
      logic [31:0] r;
      t.ts   = $random(seed);
      t.hint = $random(seed);
      t.args = $random(seed);
      r      = $random(seed);
      if (splitter_mix && r[4]) begin
         t.ttype = TASK_TYPE_SPLITTER;
      end else begin
         t.ttype = r[3:0] % 4'd15;
      end
      return t;
   endfunction

   // Holds valid until the handshake is seen, then drops it
   task automatic send_task(input logic coal, input task_t t);
      logic accepted;
      accepted = 1'b0;
      if (coal) begin
         coal_child_valid = 1'b1;
         coal_child_data  = t;
      end else begin
         task_enq_valid = 1'b1;
         task_enq_data  = t;
      end
      while (!accepted) begin
         @(negedge clk);
         accepted = coal ? coal_child_ready : task_enq_ready;
         step();
      end
      if (coal) begin
         coal_child_valid = 1'b0;
      end else begin
         task_enq_valid = 1'b0;
      end
   endtask

   task automatic drain_queue;
      logic [31:0] r;
      while (!empty) begin
         r = $random(seed);
         task_deq_ready     = r[0];
         splitter_deq_ready = r[1];
         overflow_ready     = r[2];
         step();
      end
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      overflow_ready     = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      psel    = 1'b1;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      step();
      penable = 1'b1;
      step();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr);
      psel    = 1'b1;
      pwrite  = 1'b0;
      paddr   = addr;
      step();
      penable = 1'b1;
      apb_reads++;
      step();
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   initial begin
      rstn = 1'b0;
      task_enq_valid = 1'b0;
      task_enq_data = '0;
      coal_child_valid = 1'b0;
      coal_child_data = '0;
      overflow_ready = 1'b0;
      task_deq_ready = 1'b0;
      splitter_deq_ready = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      repeat (5) @(posedge clk);
      #1 rstn = 1'b1;
      step();

      test_name = "fifo_order";
      for (int i = 0; i < N_FIFO; i++) send_task(1'b0, random_task(1'b0));
      drain_queue();

      test_name = "mixed_types";
      for (int i = 0; i < N_MIXED; i++) send_task(1'b0, random_task(1'b1));
      drain_queue();

      test_name = "priority";
      coal_child_valid = 1'b1;
      coal_child_data  = random_task(1'b1);
      task_enq_valid   = 1'b1;
      task_enq_data    = random_task(1'b1);
      step();
      coal_child_valid = 1'b0;
      send_task(1'b0, task_enq_data);
      drain_queue();

      test_name = "threshold";
      apb_write(REG_SPILL_THRESHOLD, 32'd6);
      apb_write(REG_SPILL_SIZE, 32'd5);
      for (int i = 0; i < 7; i++) send_task(1'b0, random_task(1'b1));
      // New task waits while children keep filling the queue
      task_enq_valid = 1'b1;
      task_enq_data  = random_task(1'b0);
      while (!full) begin
         send_task(1'b1, random_task(1'b1));
         task_enq_valid = 1'b1;
         step();
      end
      task_enq_valid = 1'b0;

      test_name = "spill";
      drain_queue();

      test_name = "apb";
      for (int i = 0; i < N_APB_TASKS; i++) send_task(1'b0, random_task(1'b1));
      apb_read(REG_N_TASKS);
      apb_read(REG_SPILL_THRESHOLD);
      apb_read(REG_SPILL_SIZE);
      apb_read(8'h0C);
      apb_read(8'h24);
      drain_queue();
      apb_read(REG_N_TASKS);
      apb_read(REG_N_TASK_ENQ);
      apb_read(REG_N_COAL_CHILD);
      apb_read(REG_N_TASK_DEQ);
      apb_read(REG_N_SPLITTER_DEQ);
      apb_read(REG_N_OVERFLOW);
      repeat (3) step();

      $display("Done: %0d tasks out, %0d APB reads, %0d errors",
               n_deq + n_split + n_ovf, apb_reads, error_count);
      if (error_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      #(20 * STIM_CYCLES * CLK_PERIOD);
      $display("Watchdog: run did not finish in time during test %s", test_name);
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire
